//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert
TOP      = vrc6_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
PASS_MSG = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
verilog/vrc6_pkg.sv
verilog/vrc6_cpu_if.sv
verilog/vrc6_banking.sv
verilog/vrc6_irq.sv
verilog/vrc6_pulse.sv
verilog/vrc6_saw.sv
verilog/vrc6_mapper.sv
verification/vrc6_assertions.sv
verification/vrc6_tb.sv

//--- verification/vrc6_assertions.sv
/*
 * Concurrent checks bound into vrc6_mapper.
 * Sampled on clk20, inputs are expected to change after the edge.
 */
`timescale 1ns/1ps

module vrc6_assertions (
    input logic        clk20,
    input logic        reset,
    input logic        ce,
    input logic        mapper26,
    input logic        nesprg_we,
    input logic [15:0] prgain,
    input logic [13:0] chrain,
    input logic        irq,
    input logic        wram_oe,
    input logic        wram_we,
    input logic        ciram_ce
);

    logic [1:0] low_pair;     // A1:A0 as the mapper decodes them
    logic       irq_clear_wr; // F001 control or F002 acknowledge

    assign low_pair     = mapper26 ? {prgain[0], prgain[1]} : prgain[1:0];
    assign irq_clear_wr = ce && nesprg_we && prgain[15:12] == 4'hf
                          && (low_pair == 2'd1 || low_pair == 2'd2);

    irq_low_in_reset: assert property (@(posedge clk20) reset |-> !irq)
        else $error("irq is high while reset is asserted");

    irq_low_after_clear: assert property (
        @(posedge clk20) disable iff (reset) irq_clear_wr |=> !irq
    ) else $error("irq still high one cycle after a control or acknowledge write");

    wram_one_direction: assert property (@(posedge clk20) !(wram_oe && wram_we))
        else $error("wram_oe and wram_we are high together");

    ciram_follows_a13: assert property (@(posedge clk20) ciram_ce == chrain[13])
        else $error("ciram_ce does not follow chrain[13]");

endmodule

bind vrc6_mapper vrc6_assertions assertions_i (
    .clk20     (clk20),
    .reset     (reset),
    .ce        (ce),
    .mapper26  (mapper26),
    .nesprg_we (nesprg_we),
    .prgain    (prgain),
    .chrain    (chrain),
    .irq       (irq),
    .wram_oe   (wram_oe),
    .wram_we   (wram_we),
    .ciram_ce  (ciram_ce)
);

//--- verification/vrc6_tb.sv
/*
 * Testbench for vrc6_mapper. ce is held high, so every clock is a cpu tick.
 * Inputs change 1 ns after the rising edge, checks run 1 ns later.
 */
`timescale 1ns/1ps

module vrc6_tb;

    localparam int n_writes   = 30;
    localparam int n_checks   = 531;
    localparam int timeout_ns = (n_writes + n_checks) * 20 * 10;

    logic        clk20;
    logic        reset;
    logic        ce;
    logic        mapper26;
    logic        m2_n;
    logic        nesprg_we;
    logic [15:0] prgain;
    logic [13:0] chrain;
    logic [7:0]  nesprgdin;
    logic        neschr_rd;
    logic        neschr_wr;
    logic        cfg_boot;
    logic [5:0]  cfg_prgmask;
    logic [6:0]  cfg_chrmask;
    logic        cfg_chrram;
    logic [5:0]  ramprgaout;
    logic [8:0]  ramchraout;
    logic        ciram_ce;
    logic        chrram_we;
    logic        chrram_oe;
    logic        wram_oe;
    logic        wram_we;
    logic        prgram_oe;
    logic        nesprg_oe;
    logic        irq;
    logic [5:0]  snd_level;

    int          seed;
    int          errors;
    int          checks;
    logic [31:0] rnd;
    logic [7:0]  chr_val [8]; // model of the eight chr bank registers

    vrc6_mapper dut_i (
        .clk20 (clk20), .reset (reset), .ce (ce), .mapper26 (mapper26),
        .m2_n (m2_n), .nesprg_we (nesprg_we), .prgain (prgain), .chrain (chrain),
        .nesprgdin (nesprgdin), .neschr_rd (neschr_rd), .neschr_wr (neschr_wr),
        .cfg_boot (cfg_boot), .cfg_prgmask (cfg_prgmask), .cfg_chrmask (cfg_chrmask),
        .cfg_chrram (cfg_chrram), .ramprgaout (ramprgaout), .ramchraout (ramchraout),
        .ciram_ce (ciram_ce), .chrram_we (chrram_we), .chrram_oe (chrram_oe),
        .wram_oe (wram_oe), .wram_we (wram_we), .prgram_oe (prgram_oe),
        .nesprg_oe (nesprg_oe), .irq (irq), .snd_level (snd_level)
    );

    initial begin
        clk20 = 1'b0;
        forever #5 clk20 = ~clk20;
    end

    initial begin
        #(timeout_ns);
        $display("timeout after %0d ns, the tests did not finish", timeout_ns);
        $display("Checks failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk20);
        #1;
    endtask

    // one-cycle cpu write, returns just after the edge that takes it
    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        prgain    = addr;
        nesprgdin = data;
        nesprg_we = 1'b1;
        next_cycle();
        nesprg_we = 1'b0;
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_max(input string name, input logic [15:0] got,
                             input logic [15:0] max);
        checks++;
        assert (got <= max) else begin
            errors++;
            $display("FAILED %s: expected at most %h, got %h", name, max, got);
        end
    endtask

    function automatic logic [5:0] prg_expect(input logic [15:0] a, input logic [4:0] b8,
                                              input logic [5:0] bc, input logic [5:0] mask);
        logic [5:0] bank;
        if (a < 16'h8000)
            bank = 6'd0;
        else if (a < 16'hc000)
            bank = {b8, a[13]}; // 16k bank, A13 picks the half
        else if (a < 16'he000)
            bank = bc;
        else
            bank = 6'h3f;
        return bank & mask;
    endfunction

    function automatic logic [8:0] chr_expect(input logic [13:0] a, input logic [1:0] mir,
                                              input logic [6:0] mask);
        logic [7:0] bank;
        logic       a10;
        bank = chr_val[a[12:10]];
        if (!a[13])
            a10 = bank[0];
        else if (mir == 2'd0)
            a10 = a[10];
        else if (mir == 2'd1)
            a10 = a[11];
        else
            a10 = mir[0]; // 2 -> 0, 3 -> 1
        return {1'b0, bank[7:2] & mask[5:0], bank[1], a10}; // no bank bit for A18
    endfunction

    initial begin
        logic [4:0]  b8;
        logic [5:0]  bc;
        logic [5:0]  pmask;
        logic [6:0]  cmask;
        logic [15:0] a;
        logic [3:0]  vol1;
        logic [3:0]  vol2;
        logic [5:0]  rate;
        logic [5:0]  peak;
        logic [15:0] region [4];
        logic        in_wram;
        logic        rd;
        int          wait_cycles;

        seed = 32'he587;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        ce = 1'b1;
        mapper26 = 1'b0;
        m2_n = 1'b0;
        nesprg_we = 1'b0;
        prgain = '0;
        chrain = '0;
        nesprgdin = '0;
        neschr_rd = 1'b0;
        neschr_wr = 1'b0;
        cfg_boot = 1'b0;
        cfg_prgmask = '1;
        cfg_chrmask = '1;
        cfg_chrram = 1'b0;
        repeat (16) @(posedge clk20);
        #1;
        reset = 1'b0;
        next_cycle();

        // prg windows over all four regions
        rnd = $random(seed);
        b8 = rnd[4:0];
        bc = rnd[13:8];
        pmask = rnd[21:16];
        write_reg(16'h8000, {3'b000, b8});
        write_reg(16'hc000, {2'b00, bc});
        cfg_prgmask = pmask;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            a = {i[3:0], rnd[11:0]};
            prgain = a;
            #1;
            check("ramprgaout", 16'(ramprgaout), 16'(prg_expect(a, b8, bc, pmask)));
            next_cycle();
        end

        // chr banks, then each mirror mode
        for (int b = 0; b < 8; b++) begin
            rnd = $random(seed);
            chr_val[b] = rnd[7:0];
            write_reg({(b < 4) ? 4'hd : 4'he, 10'd0, b[1:0]}, rnd[7:0]);
        end
        rnd = $random(seed);
        cmask = rnd[6:0];
        cfg_chrmask = cmask;
        for (int m = 0; m < 4; m++) begin
            write_reg(16'hb003, {4'd0, m[1:0], 2'd0});
            for (int k = 0; k < 16; k++) begin
                rnd = $random(seed);
                chrain = {k[3:0], rnd[9:0]};
                #1;
                check("ramchraout", 16'(ramchraout), 16'(chr_expect(chrain, m[1:0], cmask)));
                next_cycle();
            end
        end

        // mapper26 swaps A0 and A1
        mapper26 = 1'b1;
        cfg_chrmask = '1;
        write_reg(16'hd001, 8'h5a);
        write_reg(16'hd002, 8'hc3);
        mapper26 = 1'b0;
        chr_val[2] = 8'h5a;
        chr_val[1] = 8'hc3;
        chrain = 14'h0800; // bank 2
        #1;
        check("ramchraout", 16'(ramchraout), 16'(chr_expect(chrain, 2'd0, 7'h7f)));
        next_cycle();
        chrain = 14'h0400; // bank 1
        #1;
        check("ramchraout", 16'(ramchraout), 16'(chr_expect(chrain, 2'd0, 7'h7f)));
        next_cycle();

        // irq in cycle mode from latch FD
        write_reg(16'hf000, 8'hfd);
        write_reg(16'hf001, 8'h06); // M and E set, A clear
        wait_cycles = 0;
        while (irq !== 1'b1 && wait_cycles < 10) begin
            next_cycle();
            wait_cycles++;
        end
        check("irq", 16'(irq), 16'h1);
        write_reg(16'hf002, 8'h00);
        check("irq", 16'(irq), 16'h0);
        for (int i = 0; i < 20; i++) begin
            next_cycle();
            check("irq", 16'(irq), 16'h0);
        end

        // sound, pulses in constant mode
        rnd = $random(seed);
        vol1 = rnd[3:0];
        vol2 = rnd[7:4];
        write_reg(16'h9000, {4'h8, vol1});
        write_reg(16'h9001, 8'h10);
        write_reg(16'h9002, 8'h80);
        write_reg(16'ha000, {4'h8, vol2});
        write_reg(16'ha001, 8'h10);
        write_reg(16'ha002, 8'h80);
        check("snd_level", 16'(snd_level), 16'(vol1) + 16'(vol2));
        write_reg(16'h9002, 8'h00);
        check("snd_level", 16'(snd_level), 16'(vol2));
        write_reg(16'ha002, 8'h00);
        rate = {2'b01, rnd[11:8]}; // 16..31, six adds stay below 256
        write_reg(16'hb000, {2'b00, rate});
        write_reg(16'hb001, 8'h01);
        write_reg(16'hb002, 8'h80);
        peak = '0;
        for (int i = 0; i < 40; i++) begin
            check_max("snd_level", 16'(snd_level), 16'h1f);
            if (snd_level > peak)
                peak = snd_level;
            next_cycle();
        end
        // top of the ramp is six adds of the rate, upper five bits
        check("snd_level", 16'(peak), 16'(6 * int'(rate) / 8));

        // ram strobes
        region[0] = 16'h4020;
        region[1] = 16'h6123;
        region[2] = 16'h8456;
        region[3] = 16'he789;
        for (int v = 0; v < 64; v++) begin
            rnd = $random(seed);
            m2_n = v[0];
            nesprg_we = v[1];
            prgain = region[v[3:2]];
            cfg_boot = v[4];
            cfg_chrram = v[5];
            neschr_rd = rnd[0];
            neschr_wr = rnd[1];
            chrain = rnd[15:2];
            #1;
            in_wram = prgain >= 16'h6000 && prgain <= 16'h7fff;
            rd = m2_n && !nesprg_we;
            check("wram_oe", 16'(wram_oe), 16'(rd && in_wram));
            check("wram_we", 16'(wram_we), 16'(m2_n && nesprg_we && in_wram));
            check("prgram_oe", 16'(prgram_oe), 16'(!cfg_boot && rd && prgain >= 16'h8000));
            check("nesprg_oe", 16'(nesprg_oe),
                  16'((rd && in_wram) || (!cfg_boot && rd && prgain >= 16'h8000)));
            check("chrram_we", 16'(chrram_we), 16'(neschr_wr && !chrain[13] && cfg_chrram));
            check("chrram_oe", 16'(chrram_oe), 16'(neschr_rd && !chrain[13]));
            next_cycle();
        end
        nesprg_we = 1'b0;
        neschr_rd = 1'b0;
        neschr_wr = 1'b0;
        next_cycle();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- verilog/vrc6_banking.sv
/*
 * PRG and CHR bank registers with the address mapping.
 * Outputs are unmasked, the top level applies the cartridge size masks.
 */
`timescale 1ns/1ps

module vrc6_banking import vrc6_pkg::*; (
    input  logic                  clk20,
    input  logic                  reset,
    vrc6_cpu_if.dev               bus,
    input  logic [15:0]           prgain,
    input  logic [13:0]           chrain,
    output logic [prg_bank_w-1:0] prg_bank,
    output logic [chr_bank_w-1:0] chr_bank_out
);

    logic [prg8_bank_w-1:0] prgbank8;
    logic [prg_bank_w-1:0]  prgbankC;
    logic [chr_bank_w-1:0]  chr_bank [8];
    logic [1:0]             mirror;

    reg_code_t             code;
    logic [chr_bank_w-1:0] sel_bank;
    logic                  nt_a10;

    assign code = reg_code(bus.addr);

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            prgbank8 <= '0;
            prgbankC <= '0;
            mirror   <= '0;
            for (int i = 0; i < 8; i++) begin
                chr_bank[i] <= '0;
            end
        end else if (bus.wr) begin
            if (code[5:2] == reg_prg8[5:2])
                prgbank8 <= bus.data[prg8_bank_w-1:0];
            if (code[5:2] == reg_prgc[5:2])
                prgbankC <= bus.data[prg_bank_w-1:0];
            if (code == reg_mirror)
                mirror <= bus.data[3:2];
            if (code[5:2] == reg_chr_lo[5:2])
                chr_bank[{1'b0, code[1:0]}] <= bus.data; // D000..D003 -> banks 0..3
            if (code[5:2] == reg_chr_hi[5:2])
                chr_bank[{1'b1, code[1:0]}] <= bus.data; // E000..E003 -> banks 4..7
        end
    end

    // prg windows
    always_comb begin
        casez (prgain[15:13])
            3'b0??:  prg_bank = '0;                      // wram and below
            3'b10?:  prg_bank = {prgbank8, prgain[13]};  // 16k bank at 8000
            3'b110:  prg_bank = prgbankC;
            default: prg_bank = '1;                      // fixed last bank
        endcase
    end

    assign sel_bank = chr_bank[chrain[12:10]];

    // nametable mirroring
    always_comb begin
        case (mirror)
            2'd0:    nt_a10 = chrain[10]; // vertical
            2'd1:    nt_a10 = chrain[11]; // horizontal
            2'd2:    nt_a10 = 1'b0;
            default: nt_a10 = 1'b1;
        endcase
    end

    assign chr_bank_out = {sel_bank[chr_bank_w-1:1], chrain[13] ? nt_a10 : sel_bank[0]};

endmodule

//--- verilog/vrc6_cpu_if.sv
/*
 * CPU write bus shared by the mapper blocks.
 * wr is already qualified by tick, one cycle per write, no acknowledge.
 */
`timescale 1ns/1ps

interface vrc6_cpu_if import vrc6_pkg::*; ();

    logic                  tick; // cpu clock enable
    logic                  wr;   // register write strobe
    logic [cpu_addr_w-1:0] addr; // A0/A1 already swapped for mapper26
    logic [cpu_data_w-1:0] data;

    modport host (
        output tick,
        output wr,
        output addr,
        output data
    );

    modport dev (
        input tick,
        input wr,
        input addr,
        input data
    );

endinterface

//--- verilog/vrc6_irq.sv
/*
 * VRC6 IRQ counter, scanline mode through the prescaler or cycle mode.
 * irq stays high until a control or acknowledge write.
 */
`timescale 1ns/1ps

module vrc6_irq import vrc6_pkg::*; (
    input  logic    clk20,
    input  logic    reset,
    vrc6_cpu_if.dev bus,
    output logic    irq
);

    logic [7:0] irq_latch;
    logic       irq_m;      // cycle mode
    logic       irq_a;      // enable after ack
    logic       irq_e;
    logic [6:0] prescaler;
    logic [1:0] line;       // picks the short reload every third line
    logic [7:0] counter;
    logic       timeout;

    reg_code_t code;
    logic      latch_wr;
    logic      ctrl_wr;
    logic      ack_wr;
    logic      irq_clk;
    logic      count_run;
    logic      count_hit;

    assign code     = reg_code(bus.addr);
    assign latch_wr = bus.wr && code == reg_irq_latch;
    assign ctrl_wr  = bus.wr && code == reg_irq_ctrl;
    assign ack_wr   = bus.wr && code == reg_irq_ack;

    assign irq_clk   = irq_m || prescaler == '0;
    assign count_run = bus.tick && irq_e;
    assign count_hit = count_run && irq_clk && counter == irq_count_max;

    always_ff @(posedge clk20) begin
        if (latch_wr)
            irq_latch <= bus.data;
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            irq_m     <= 1'b0;
            irq_a     <= 1'b0;
            irq_e     <= 1'b0;
            timeout   <= 1'b0;
            prescaler <= irq_prescale_long;
            line      <= '0;
            counter   <= '0;
        end else if (ctrl_wr) begin
            irq_m   <= bus.data[2];
            irq_a   <= bus.data[0];
            irq_e   <= bus.data[1];
            timeout <= 1'b0;
            if (bus.data[1]) begin // enabling restarts the count from the latch
                prescaler <= irq_prescale_long;
                line      <= '0;
                counter   <= irq_latch;
            end
        end else begin
            if (ack_wr)
                irq_e <= irq_a;

            if (count_run) begin
                if (prescaler != '0) begin
                    prescaler <= prescaler - 7'd1;
                end else begin
                    prescaler <= line[1] ? irq_prescale_short : irq_prescale_long;
                    line      <= line[1] ? 2'd0 : line + 2'd1;
                end
                if (irq_clk)
                    counter <= (counter == irq_count_max) ? irq_latch : counter + 8'd1;
            end

            if (ack_wr)
                timeout <= 1'b0;
            else if (count_hit)
                timeout <= 1'b1;
        end
    end

    assign irq = timeout & irq_e;

endmodule

//--- verilog/vrc6_mapper.sv
/*
 * VRC6 mapper top, mapper26 high selects the A0/A1 swapped variant.
 * Masks are per address bit, prg 18:13 and chr 18:12.
 * snd_level is the raw sum of the three channels, 0..61.
 */
`timescale 1ns/1ps

module vrc6_mapper import vrc6_pkg::*; (
    input  logic                   clk20,
    input  logic                   reset,
    input  logic                   ce,
    input  logic                   mapper26,
    input  logic                   m2_n,
    input  logic                   nesprg_we,
    input  logic [15:0]            prgain,
    input  logic [13:0]            chrain,
    input  logic [cpu_data_w-1:0]  nesprgdin,
    input  logic                   neschr_rd,
    input  logic                   neschr_wr,
    input  logic                   cfg_boot,
    input  logic [5:0]             cfg_prgmask,
    input  logic [6:0]             cfg_chrmask,
    input  logic                   cfg_chrram,
    output logic [prg_bank_w-1:0]  ramprgaout,
    output logic [chr_out_w-1:0]   ramchraout,
    output logic                   ciram_ce,
    output logic                   chrram_we,
    output logic                   chrram_oe,
    output logic                   wram_oe,
    output logic                   wram_we,
    output logic                   prgram_oe,
    output logic                   nesprg_oe,
    output logic                   irq,
    output logic [snd_level_w-1:0] snd_level
);

    vrc6_cpu_if cpu_bus ();

    logic [prg_bank_w-1:0]   prg_bank;
    logic [chr_bank_w-1:0]   chr_bank_out;
    logic [chan_level_w-1:0] sq1_level;
    logic [chan_level_w-1:0] sq2_level;
    logic [saw_level_w-1:0]  saw_level;
    logic                    wram_sel;

    assign cpu_bus.tick = ce;
    assign cpu_bus.wr   = ce & nesprg_we;
    assign cpu_bus.addr = mapper26 ? {prgain[15:2], prgain[0], prgain[1]} : prgain;
    assign cpu_bus.data = nesprgdin;

    vrc6_banking banking_i (
        .clk20        (clk20),
        .reset        (reset),
        .bus          (cpu_bus),
        .prgain       (prgain),
        .chrain       (chrain),
        .prg_bank     (prg_bank),
        .chr_bank_out (chr_bank_out)
    );

    vrc6_irq irq_i (
        .clk20 (clk20),
        .reset (reset),
        .bus   (cpu_bus),
        .irq   (irq)
    );

    vrc6_pulse #(.base_addr(reg_pulse1_base)) pulse1_i (
        .clk20 (clk20),
        .reset (reset),
        .bus   (cpu_bus),
        .level (sq1_level)
    );

    vrc6_pulse #(.base_addr(reg_pulse2_base)) pulse2_i (
        .clk20 (clk20),
        .reset (reset),
        .bus   (cpu_bus),
        .level (sq2_level)
    );

    vrc6_saw saw_i (
        .clk20 (clk20),
        .reset (reset),
        .bus   (cpu_bus),
        .level (saw_level)
    );

    // size masks, chr bit 18 is never driven by a bank
    assign ramprgaout = prg_bank & cfg_prgmask;
    assign ramchraout = {({1'b0, chr_bank_out[7:2]} & cfg_chrmask), chr_bank_out[1:0]};

    // ram strobes
    assign wram_sel  = prgain[15:13] == 3'b011; // 6000..7FFF
    assign wram_oe   = m2_n & ~nesprg_we & wram_sel;
    assign wram_we   = m2_n & nesprg_we & wram_sel;
    assign prgram_oe = ~cfg_boot & m2_n & ~nesprg_we & prgain[15];
    assign nesprg_oe = wram_oe | prgram_oe;

    assign chrram_we = neschr_wr & ~chrain[13] & cfg_chrram;
    assign chrram_oe = neschr_rd & ~chrain[13];
    assign ciram_ce  = chrain[13]; // nametables go to console vram

    assign snd_level = {2'b00, sq1_level} + {2'b00, sq2_level} + {1'b0, saw_level};

endmodule

//--- verilog/vrc6_pkg.sv
/*
 * VRC6 mapper constants, widths and register codes.
 * Register codes are {A15:A12, A1:A0} after the mapper26 line swap.
 */
package vrc6_pkg;

    // bus widths
    localparam int cpu_data_w = 8;
    localparam int cpu_addr_w = 16;

    // prg fields, bank output covers address bits 18:13
    localparam int prg_bank_w  = 6;
    localparam int prg8_bank_w = 5;

    // chr fields, output covers address bits 18:10
    localparam int chr_bank_w = 8;
    localparam int chr_out_w  = 9;

    typedef logic [5:0] reg_code_t;

    localparam reg_code_t reg_prg8        = 6'b1000_00; // 8xxx, low pair ignored
    localparam reg_code_t reg_prgc        = 6'b1100_00; // Cxxx, low pair ignored
    localparam reg_code_t reg_mirror      = 6'b1011_11; // B003
    localparam reg_code_t reg_chr_lo      = 6'b1101_00; // D000..D003
    localparam reg_code_t reg_chr_hi      = 6'b1110_00; // E000..E003
    localparam reg_code_t reg_irq_latch   = 6'b1111_00; // F000
    localparam reg_code_t reg_irq_ctrl    = 6'b1111_01; // F001
    localparam reg_code_t reg_irq_ack     = 6'b1111_10; // F002
    localparam reg_code_t reg_pulse1_base = 6'b1001_00; // 9000
    localparam reg_code_t reg_pulse2_base = 6'b1010_00; // A000
    localparam reg_code_t reg_saw_base    = 6'b1011_00; // B000

    // scanline prescaler, 113 113 112 approximates 341/3 cpu cycles
    localparam logic [6:0] irq_prescale_long  = 7'd113;
    localparam logic [6:0] irq_prescale_short = 7'd112;
    localparam logic [7:0] irq_count_max      = 8'd255;

    // sound
    localparam logic [2:0] saw_steps    = 3'd6;
    localparam int         chan_level_w = 4;
    localparam int         saw_level_w  = 5;
    localparam int         snd_level_w  = 6;

    function automatic reg_code_t reg_code(input logic [cpu_addr_w-1:0] addr);
        return {addr[15:12], addr[1:0]};
    endfunction

endpackage

//--- verilog/vrc6_pulse.sv
/*
 * One VRC6 pulse channel. base_addr selects the register triple
 * (base+0 mode/duty/volume, +1 period low, +2 enable/period high).
 */
`timescale 1ns/1ps

module vrc6_pulse import vrc6_pkg::*; #(
    parameter reg_code_t base_addr = reg_pulse1_base
) (
    input  logic                    clk20,
    input  logic                    reset,
    vrc6_cpu_if.dev                 bus,
    output logic [chan_level_w-1:0] level
);

    logic                    mode;   // constant output, duty ignored
    logic [2:0]              duty;
    logic [chan_level_w-1:0] volume;
    logic [11:0]             period;
    logic                    enable;
    logic [11:0]             divider;
    logic [3:0]              step;

    reg_code_t code;
    logic      sel;

    assign code = reg_code(bus.addr);
    assign sel  = bus.wr && code[5:2] == base_addr[5:2];

    always_ff @(posedge clk20) begin
        if (sel) begin
            case (code[1:0])
                2'd0:    {mode, duty, volume} <= bus.data;
                2'd1:    period[7:0] <= bus.data;
                2'd2:    period[11:8] <= bus.data[3:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            enable  <= 1'b0;
            divider <= '0;
            step    <= '0;
        end else begin
            if (sel && code[1:0] == 2'd2)
                enable <= bus.data[7];
            if (bus.tick && enable) begin
                if (divider != '0) begin
                    divider <= divider - 12'd1;
                end else begin
                    divider <= period;
                    step    <= step + 4'd1; // 16 steps per cycle
                end
            end
        end
    end

    assign level = (enable && (mode || step <= {1'b0, duty})) ? volume : '0;

endmodule

//--- verilog/vrc6_saw.sv
/*
 * VRC6 sawtooth channel at B000..B002.
 * The accumulator runs 6 additions then clears, so a large rate wraps.
 */
`timescale 1ns/1ps

module vrc6_saw import vrc6_pkg::*; (
    input  logic                   clk20,
    input  logic                   reset,
    vrc6_cpu_if.dev                bus,
    output logic [saw_level_w-1:0] level
);

    logic [5:0]  rate;
    logic [11:0] period;
    logic        enable;
    logic [12:0] divider;
    logic [2:0]  step;
    logic [7:0]  acc;

    reg_code_t code;
    logic      sel;

    assign code = reg_code(bus.addr);
    assign sel  = bus.wr && code[5:2] == reg_saw_base[5:2];

    always_ff @(posedge clk20) begin
        if (sel) begin
            case (code[1:0])
                2'd0:    rate <= bus.data[5:0];
                2'd1:    period[7:0] <= bus.data;
                2'd2:    period[11:8] <= bus.data[3:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            enable  <= 1'b0;
            divider <= '0;
            step    <= '0;
            acc     <= '0;
        end else begin
            if (sel && code[1:0] == 2'd2)
                enable <= bus.data[7];
            if (bus.tick && enable) begin
                if (divider != '0) begin
                    divider <= divider - 13'd1;
                end else begin
                    divider <= {period, 1'b1}; // doubled period, one add per two expiries
                    if (step == saw_steps) begin
                        step <= '0;
                        acc  <= '0;
                    end else begin
                        step <= step + 3'd1;
                        acc  <= acc + {2'b00, rate};
                    end
                end
            end
        end
    end

    assign level = enable ? acc[7:3] : '0;

endmodule
